// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0 --timescale 1ns/1ps
TOP       ?= spi_ctrl_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+logic
logic/spi_ctrl_pkg.sv
logic/spi_pin_sync.sv
logic/reg_frame_shifter.sv
logic/ctrl_reg_file.sv
logic/periph_cs_router.sv
logic/spi_ctrl_top.sv
verif/spi_ctrl_props.sv
verif/spi_ctrl_tb.sv

// ==== logic/ctrl_reg_file.sv ====
/*
  control register file
  set/clear/toggle nibble registers, mux byte, reset and
  power-up commands, combinational readback
*/
`include "spi_ctrl_cfg.svh"

module ctrl_reg_file (
  input  logic                     clk,
  input  logic                     reset,
  input  spi_ctrl_pkg::frame_evt_t frame_evt,
  input  spi_ctrl_pkg::reg_addr_t  read_addr,
  output spi_ctrl_pkg::reg_byte_t  read_data,
  output spi_ctrl_pkg::ctl_regs_t  regs
);

  // low nibble sets, high nibble clears, overlap toggles
  function automatic spi_ctrl_pkg::ctl_nibble_t nibble_update(
    input spi_ctrl_pkg::ctl_nibble_t old_val,
    input spi_ctrl_pkg::reg_byte_t   wr_data
  );
    spi_ctrl_pkg::ctl_nibble_t set_bits;
    spi_ctrl_pkg::ctl_nibble_t clr_bits;
    set_bits = wr_data[3:0];
    clr_bits = wr_data[7:4];
    if ((set_bits & clr_bits) != '0)
      return old_val ^ (set_bits & clr_bits);
    else
      return (old_val | set_bits) & ~clr_bits;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // writes and commands
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regs.led       <= '0;
      regs.gpio_4094 <= '0;
      regs.dac       <= `SPI_DAC_RESET_VAL;
      regs.adc       <= '0;
      regs.spi_mux   <= '0;
    end
    else if (frame_evt.valid)
    begin
      case (frame_evt.addr)
        `SPI_REG_LED:  regs.led       <= nibble_update(regs.led, frame_evt.data);
        `SPI_REG_4094: regs.gpio_4094 <= nibble_update(regs.gpio_4094, frame_evt.data);
        `SPI_REG_DAC:  regs.dac       <= nibble_update(regs.dac, frame_evt.data);
        `SPI_REG_ADC:  regs.adc       <= nibble_update(regs.adc, frame_evt.data);
        // mux byte taken as is
        `SPI_REG_MUX:  regs.spi_mux   <= frame_evt.data;
        `SPI_REG_SOFT_RESET:
        begin
          // 4094 outputs survive a soft reset
          regs.led     <= '0;
          regs.spi_mux <= '0;
          regs.dac     <= '0;
          regs.adc     <= '0;
        end
        `SPI_REG_POWERUP:
        begin
          // dac already configured before rails come up, leave it
          regs.led <= '0;
          regs.adc <= '0;
        end
        default:
        begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback, nibbles zero-extended
  always_comb
  begin
    case (read_addr)
      `SPI_REG_LED:  read_data = {4'b0000, regs.led};
      `SPI_REG_4094: read_data = {4'b0000, regs.gpio_4094};
      `SPI_REG_DAC:  read_data = {4'b0000, regs.dac};
      `SPI_REG_ADC:  read_data = {4'b0000, regs.adc};
      `SPI_REG_MUX:  read_data = regs.spi_mux;
      default:       read_data = '0;
    endcase
  end

endmodule

// ==== logic/periph_cs_router.sv ====
/*
  peripheral chip select router
  mux register picks one peripheral for cs2_n, miso merged
  from the register shifter or that peripheral
*/
`include "spi_ctrl_cfg.svh"

module periph_cs_router (
  input  spi_ctrl_pkg::reg_byte_t   spi_mux,
  input  logic                      cs2_n,
  input  logic                      reg_dout,
  input  spi_ctrl_pkg::periph_vec_t periph_miso,
  output spi_ctrl_pkg::periph_vec_t periph_cs,
  output logic                      miso
);

  localparam spi_ctrl_pkg::periph_vec_t ACTIVE_HIGH = `SPI_PERIPH_ACTIVE_HIGH;

  spi_ctrl_pkg::periph_vec_t sel;
  spi_ctrl_pkg::periph_vec_t active;

  // mux value n selects peripheral n-1, 0 and >8 select none
  always_comb
  begin
    for (int i = 0; i < `SPI_PERIPH_COUNT; i++)
      sel[i] = (spi_mux == 8'(i + 1));
  end

  // only drive a select while the host holds cs2_n low
  assign active = sel & {`SPI_PERIPH_COUNT{~cs2_n}};

  // active-low lines inverted, strobes passed straight
  assign periph_cs = active ^ ~ACTIVE_HIGH;

  // register data when cs2_n idle, else the selected peripheral
  assign miso = cs2_n ? reg_dout : |(sel & periph_miso);

endmodule

// ==== logic/reg_frame_shifter.sv ====
/*
  register frame shifter
  collects address and data bytes under cs_n, shifts read data
  out MSB first and reports each complete 16-bit frame
*/
`include "spi_ctrl_cfg.svh"

module reg_frame_shifter (
  input  logic                     clk,
  input  logic                     reset,
  input  spi_ctrl_pkg::spi_edges_t edges,
  output spi_ctrl_pkg::reg_addr_t  read_addr,
  input  spi_ctrl_pkg::reg_byte_t  read_data,
  output logic                     reg_dout,
  output spi_ctrl_pkg::frame_evt_t frame_evt
);

  // bit counts that mark the byte boundaries
  localparam spi_ctrl_pkg::frame_cnt_t ADDR_LAST  = 5'(`SPI_FRAME_BITS / 2 - 1);
  localparam spi_ctrl_pkg::frame_cnt_t DATA_FIRST = 5'(`SPI_FRAME_BITS / 2);
  localparam spi_ctrl_pkg::frame_cnt_t FRAME_LAST = 5'(`SPI_FRAME_BITS - 1);
  localparam spi_ctrl_pkg::frame_cnt_t FRAME_FULL = 5'(`SPI_FRAME_BITS);

  spi_ctrl_pkg::shifter_state_e state_q;
  spi_ctrl_pkg::frame_cnt_t     cnt_q;
  spi_ctrl_pkg::reg_byte_t      shift_q;
  spi_ctrl_pkg::reg_addr_t      addr_q;
  spi_ctrl_pkg::reg_byte_t      tx_q;
  logic                         evt_valid_q;

  //////////////////////////////////////////////////////////////////////
  // frame state machine
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q     <= spi_ctrl_pkg::SHIFT_IDLE;
      cnt_q       <= '0;
      reg_dout    <= 1'b0;
      evt_valid_q <= 1'b0;
    end
    else
    begin
      evt_valid_q <= 1'b0;
      if (edges.cs_close)
      begin
        // resync on every deassert, write only a full frame
        evt_valid_q <= (cnt_q == FRAME_FULL);
        state_q     <= spi_ctrl_pkg::SHIFT_IDLE;
        reg_dout    <= 1'b0;
      end
      else if (edges.cs_open)
      begin
        state_q <= spi_ctrl_pkg::SHIFT_ADDR;
        cnt_q   <= '0;
        tx_q    <= '0;
      end
      else if (edges.sclk_rise)
      begin
        case (state_q)
          spi_ctrl_pkg::SHIFT_ADDR:
          begin
            shift_q <= {shift_q[6:0], edges.pins.mosi};
            cnt_q   <= cnt_q + 5'd1;
            if (cnt_q == ADDR_LAST)
            begin
              // address complete, hold it for the read lookup
              addr_q  <= {shift_q[6:0], edges.pins.mosi};
              state_q <= spi_ctrl_pkg::SHIFT_DATA;
            end
          end
          spi_ctrl_pkg::SHIFT_DATA:
          begin
            shift_q <= {shift_q[6:0], edges.pins.mosi};
            cnt_q   <= cnt_q + 5'd1;
            if (cnt_q == FRAME_LAST)
              state_q <= spi_ctrl_pkg::SHIFT_DRAIN;
          end
          spi_ctrl_pkg::SHIFT_DRAIN:
          begin
            // extra clocks spoil the frame, saturate the count
            if (cnt_q != '1)
              cnt_q <= cnt_q + 5'd1;
          end
          default:
          begin
          end
        endcase
      end
      else if (edges.sclk_fall && state_q != spi_ctrl_pkg::SHIFT_IDLE
               && state_q != spi_ctrl_pkg::SHIFT_ADDR)
      begin
        if (cnt_q == DATA_FIRST)
        begin
          // first fall after bit 8, read word goes out MSB first
          reg_dout <= read_data[7];
          tx_q     <= {read_data[6:0], 1'b0};
        end
        else
        begin
          reg_dout <= tx_q[7];
          tx_q     <= {tx_q[6:0], 1'b0};
        end
      end
    end
  end

  assign read_addr = addr_q;

  // payload stays put until the next cs_open
  assign frame_evt = '{valid: evt_valid_q, addr: addr_q, data: shift_q};

endmodule

// ==== logic/spi_ctrl_cfg.svh ====
/*
  spi control block configuration
  register map, frame length, peripheral count and reset values
*/
`ifndef SPI_CTRL_CFG_SVH
`define SPI_CTRL_CFG_SVH

// register map, one address byte each
`define SPI_REG_POWERUP        8'd6
`define SPI_REG_LED            8'd7
`define SPI_REG_MUX            8'd8
`define SPI_REG_4094           8'd9
`define SPI_REG_DAC            8'd10
`define SPI_REG_SOFT_RESET     8'd11
`define SPI_REG_ADC            8'd14

// address byte then data byte
`define SPI_FRAME_BITS         16

// downstream peripherals behind cs2_n
`define SPI_PERIPH_COUNT       8
// strobe lines 4..6 are active high, the rest active low
`define SPI_PERIPH_ACTIVE_HIGH 8'h70

// dac control comes up with all lines high
`define SPI_DAC_RESET_VAL      4'b1111

`endif

// ==== logic/spi_ctrl_pkg.sv ====
/*
  spi control block types
  shared vectors, pin and event structs, shifter states
*/
`include "spi_ctrl_cfg.svh"

package spi_ctrl_pkg;

  // plain vectors with a meaning
  typedef logic [7:0]                     reg_addr_t;
  typedef logic [7:0]                     reg_byte_t;
  typedef logic [3:0]                     ctl_nibble_t;
  typedef logic [`SPI_PERIPH_COUNT-1:0]   periph_vec_t;
  typedef logic [4:0]                     frame_cnt_t;

  // raw pin levels, after sampling
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic cs2_n;
    logic mosi;
  } spi_pins_t;

  // synchronized levels plus single-cycle strobes
  typedef struct packed {
    spi_pins_t pins;
    logic      sclk_rise;
    logic      sclk_fall;
    // cs_n falling / rising
    logic      cs_open;
    logic      cs_close;
  } spi_edges_t;

  // one completed host frame
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    reg_byte_t data;
  } frame_evt_t;

  typedef struct packed {
    ctl_nibble_t led;
    ctl_nibble_t gpio_4094;
    ctl_nibble_t dac;
    ctl_nibble_t adc;
    reg_byte_t   spi_mux;
  } ctl_regs_t;

  typedef enum logic [1:0] {
    SHIFT_IDLE,
    SHIFT_ADDR,
    SHIFT_DATA,
    SHIFT_DRAIN
  } shifter_state_e;

endpackage

// ==== logic/spi_ctrl_top.sv ====
/*
  spi control block top level
  pin synchronizer, frame shifter, register file and router
*/
module spi_ctrl_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        sclk,
  input  logic                        cs_n,
  input  logic                        cs2_n,
  input  logic                        mosi,
  output logic                        miso,
  input  spi_ctrl_pkg::periph_vec_t   periph_miso,
  output spi_ctrl_pkg::periph_vec_t   periph_cs,
  output spi_ctrl_pkg::ctl_nibble_t   led,
  output spi_ctrl_pkg::ctl_nibble_t   gpio_4094,
  output spi_ctrl_pkg::ctl_nibble_t   dac_ctl,
  output spi_ctrl_pkg::ctl_nibble_t   adc_ctl
);

  spi_ctrl_pkg::spi_pins_t  pins;
  spi_ctrl_pkg::spi_edges_t edges;
  spi_ctrl_pkg::reg_addr_t  read_addr;
  spi_ctrl_pkg::reg_byte_t  read_data;
  spi_ctrl_pkg::frame_evt_t frame_evt;
  spi_ctrl_pkg::ctl_regs_t  regs;
  logic                     reg_dout;

  assign pins = '{sclk: sclk, cs_n: cs_n, cs2_n: cs2_n, mosi: mosi};

  //////////////////////////////////////////////////////////////////////
  // host side, register access on cs_n
  spi_pin_sync i_spi_pin_sync (
    .clk   (clk),
    .reset (reset),
    .pins  (pins),
    .edges (edges)
  );

  reg_frame_shifter i_reg_frame_shifter (
    .clk       (clk),
    .reset     (reset),
    .edges     (edges),
    .read_addr (read_addr),
    .read_data (read_data),
    .reg_dout  (reg_dout),
    .frame_evt (frame_evt)
  );

  ctrl_reg_file i_ctrl_reg_file (
    .clk       (clk),
    .reset     (reset),
    .frame_evt (frame_evt),
    .read_addr (read_addr),
    .read_data (read_data),
    .regs      (regs)
  );

  //////////////////////////////////////////////////////////////////////
  // peripheral side, pass-through on cs2_n
  periph_cs_router i_periph_cs_router (
    .spi_mux     (regs.spi_mux),
    .cs2_n       (edges.pins.cs2_n),
    .reg_dout    (reg_dout),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .miso        (miso)
  );

  // control nibbles out to the board
  assign led       = regs.led;
  assign gpio_4094 = regs.gpio_4094;
  assign dac_ctl   = regs.dac;
  assign adc_ctl   = regs.adc;

endmodule

// ==== logic/spi_pin_sync.sv ====
/*
  spi pin synchronizer
  two flops per pin into clk, then registered edge strobes
*/
module spi_pin_sync (
  input  logic                     clk,
  input  logic                     reset,
  input  spi_ctrl_pkg::spi_pins_t  pins,
  output spi_ctrl_pkg::spi_edges_t edges
);

  // idle bus, both selects deasserted
  localparam spi_ctrl_pkg::spi_pins_t PINS_IDLE = 4'b0110;

  spi_ctrl_pkg::spi_pins_t meta_q;
  spi_ctrl_pkg::spi_pins_t sync_q;

  //////////////////////////////////////////////////////////////////////
  // two-stage synchronizer
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      meta_q <= PINS_IDLE;
      sync_q <= PINS_IDLE;
    end
    else
    begin
      meta_q <= pins;
      sync_q <= meta_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // edges, previous level is the registered copy in edges.pins
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      edges.pins      <= PINS_IDLE;
      edges.sclk_rise <= 1'b0;
      edges.sclk_fall <= 1'b0;
      edges.cs_open   <= 1'b0;
      edges.cs_close  <= 1'b0;
    end
    else
    begin
      edges.pins      <= sync_q;
      edges.sclk_rise <= sync_q.sclk & ~edges.pins.sclk;
      edges.sclk_fall <= ~sync_q.sclk & edges.pins.sclk;
      // cs_n is active low, open on its falling edge
      edges.cs_open   <= ~sync_q.cs_n & edges.pins.cs_n;
      edges.cs_close  <= sync_q.cs_n & ~edges.pins.cs_n;
    end
  end

endmodule

// ==== verif/spi_ctrl_props.sv ====
/*
  spi control block assertions
  select exclusivity, idle selects and register stability,
  bound onto the top level
*/
`include "spi_ctrl_cfg.svh"

module spi_ctrl_props (
  input logic                      clk,
  input logic                      reset,
  input logic                      cs_n,
  input logic                      cs2_n,
  input spi_ctrl_pkg::periph_vec_t periph_cs,
  input spi_ctrl_pkg::ctl_regs_t   regs
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam spi_ctrl_pkg::periph_vec_t ACTIVE_HIGH = `SPI_PERIPH_ACTIVE_HIGH;

  spi_ctrl_pkg::periph_vec_t active;

  // one bit per line that sits at its active level
  assign active = periph_cs ^ ~ACTIVE_HIGH;

  //////////////////////////////////////////////////////////////////////
  a_one_select: assert property (@(posedge clk) disable iff (reset)
    $onehot0(active))
    else $error("more than one peripheral select active, periph_cs %b", periph_cs);

  // selects follow the cs2_n pin three cycles late
  a_idle_select: assert property (@(posedge clk) disable iff (reset)
    $past(cs2_n, 3) |-> (active == '0))
    else $error("peripheral select active with cs2_n high, periph_cs %b", periph_cs);

  // writes only land after the frame closes
  a_regs_stable: assert property (@(posedge clk) disable iff (reset)
    (!cs_n && $past(!cs_n)) |-> $stable(regs))
    else $error("control registers changed while cs_n was low");

endmodule

bind spi_ctrl_top spi_ctrl_props i_spi_ctrl_props (
  .clk       (clk),
  .reset     (reset),
  .cs_n      (cs_n),
  .cs2_n     (cs2_n),
  .periph_cs (periph_cs),
  .regs      (regs)
);

// ==== verif/spi_ctrl_tb.sv ====
/*
  spi control block testbench
  bit-bangs host frames, checks register pins, readback and
  peripheral routing against a model of the register rules
*/
`include "spi_ctrl_cfg.svh"

module spi_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // clk cycles per sclk phase
  localparam int HALF_BIT = 4;
  // bit is two phases plus mosi and sample slots, then select and write settle
  localparam int FRAME_CYCLES   = 16 * (2 * HALF_BIT + 2) + 2 * HALF_BIT + 16;
  localparam int MAX_FRAMES     = 60;
  localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES;
  // all selects at their inactive level
  localparam logic [7:0] CS_IDLE = ~`SPI_PERIPH_ACTIVE_HIGH;

  logic                      clk;
  logic                      reset;
  logic                      sclk;
  logic                      cs_n;
  logic                      cs2_n;
  logic                      mosi;
  logic                      miso;
  spi_ctrl_pkg::periph_vec_t periph_miso;
  spi_ctrl_pkg::periph_vec_t periph_cs;
  spi_ctrl_pkg::ctl_nibble_t led;
  spi_ctrl_pkg::ctl_nibble_t gpio_4094;
  spi_ctrl_pkg::ctl_nibble_t dac_ctl;
  spi_ctrl_pkg::ctl_nibble_t adc_ctl;

  // expected register contents
  spi_ctrl_pkg::ctl_regs_t model;
  logic [15:0]             lfsr_state;
  int                      error_count;
  int                      check_count;
  int unsigned             cycle_count = 0;

  spi_ctrl_top i_spi_ctrl_top (
    .clk         (clk),
    .reset       (reset),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .cs2_n       (cs2_n),
    .mosi        (mosi),
    .miso        (miso),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .led         (led),
    .gpio_4094   (gpio_4094),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // timeout
  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  initial
  begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one lfsr step per bit taken
  task automatic rand_byte(output logic [7:0] value);
    for (int i = 0; i < 8; i++)
    begin
      value[i]   = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    check_count++;
    if (got !== expected)
    begin
      error_count++;
      $display("Mismatch at %0d ns: %s got 0x%0h, expected 0x%0h",
               $time, name, got, expected);
    end
  endtask

  // low nibble sets, high nibble clears, any overlap toggles only the overlap
  function automatic logic [3:0] nibble_after_write(input logic [3:0] old_val,
                                                    input logic [7:0] data);
    logic [3:0] result;
    logic       overlap;
    result  = old_val;
    overlap = 1'b0;
    for (int i = 0; i < 4; i++)
      if (data[i] && data[i + 4])
        overlap = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      if (overlap)
      begin
        if (data[i] && data[i + 4])
          result[i] = ~old_val[i];
      end
      else if (data[i + 4])
        result[i] = 1'b0;
      else if (data[i])
        result[i] = 1'b1;
    end
    return result;
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
    case (addr)
      `SPI_REG_LED:  model.led       = nibble_after_write(model.led, data);
      `SPI_REG_4094: model.gpio_4094 = nibble_after_write(model.gpio_4094, data);
      `SPI_REG_DAC:  model.dac       = nibble_after_write(model.dac, data);
      `SPI_REG_ADC:  model.adc       = nibble_after_write(model.adc, data);
      `SPI_REG_MUX:  model.spi_mux   = data;
      `SPI_REG_SOFT_RESET:
      begin
        model.led     = 4'h0;
        model.spi_mux = 8'h00;
        model.dac     = 4'h0;
        model.adc     = 4'h0;
      end
      `SPI_REG_POWERUP:
      begin
        model.led = 4'h0;
        model.adc = 4'h0;
      end
      default:
      begin
      end
    endcase
  endtask

  function automatic logic [7:0] expected_readback(input logic [7:0] addr);
    case (addr)
      `SPI_REG_LED:  return {4'h0, model.led};
      `SPI_REG_4094: return {4'h0, model.gpio_4094};
      `SPI_REG_DAC:  return {4'h0, model.dac};
      `SPI_REG_ADC:  return {4'h0, model.adc};
      `SPI_REG_MUX:  return model.spi_mux;
      default:       return 8'h00;
    endcase
  endfunction

  // mux n picks peripheral n-1 and anything else picks none
  function automatic logic [7:0] expected_cs(input int mux);
    logic [7:0] result;
    result = CS_IDLE;
    if (mux >= 1 && mux <= 8)
      result[mux - 1] = ~result[mux - 1];
    return result;
  endfunction

  function automatic logic expected_miso(input int mux, input logic [7:0] pattern);
    if (mux >= 1 && mux <= 8)
      return pattern[mux - 1];
    return 1'b0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // mode 0 host frame sent msb first and the bits seen on miso returned
  task automatic spi_frame(input logic [7:0] addr, input logic [7:0] data,
                           input int nbits, output logic [15:0] rx);
    logic [15:0] word;
    word = {addr, data};
    rx   = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF_BIT) @(posedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      // mosi moves while sclk is low
      mosi <= word[15 - i];
      repeat (HALF_BIT) @(posedge clk);
      sclk <= 1'b1;
      repeat (HALF_BIT) @(posedge clk);
      // sample late in the high phase
      @(negedge clk);
      rx = {rx[14:0], miso};
      @(posedge clk);
      sclk <= 1'b0;
      @(posedge clk);
    end
    repeat (HALF_BIT) @(posedge clk);
    cs_n <= 1'b1;
    mosi <= 1'b0;
    // write lands within 5 cycles of cs_n rising
    repeat (8) @(posedge clk);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    logic [15:0] rx;
    spi_frame(addr, data, 16, rx);
    model_write(addr, data);
  endtask

  // a zero nibble write changes nothing and the mux gets its own value back
  task automatic read_check(input string name, input logic [7:0] addr);
    logic [15:0] rx;
    logic [7:0]  data;
    data = (addr == `SPI_REG_MUX) ? model.spi_mux : 8'h00;
    spi_frame(addr, data, 16, rx);
    check_value(name, 16'(rx[7:0]), 16'(expected_readback(addr)));
  endtask

  task automatic check_pins();
    @(negedge clk);
    check_value("led", 16'(led), 16'(model.led));
    check_value("gpio_4094", 16'(gpio_4094), 16'(model.gpio_4094));
    check_value("dac_ctl", 16'(dac_ctl), 16'(model.dac));
    check_value("adc_ctl", 16'(adc_ctl), 16'(model.adc));
  endtask

  task automatic read_all();
    read_check("read led", `SPI_REG_LED);
    read_check("read 4094", `SPI_REG_4094);
    read_check("read dac", `SPI_REG_DAC);
    read_check("read adc", `SPI_REG_ADC);
    read_check("read mux", `SPI_REG_MUX);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  task automatic test_reset_state();
    @(negedge clk);
    check_value("periph_cs", 16'(periph_cs), 16'(CS_IDLE));
    check_value("miso", 16'(miso), 16'h0000);
    check_value("dac_ctl", 16'(dac_ctl), 16'h000F);
    check_pins();
    read_all();
    read_check("read unused", 8'h03);
  endtask

  task automatic test_write_readback();
    write_reg(`SPI_REG_LED, 8'h05);
    write_reg(`SPI_REG_4094, 8'h0B);
    write_reg(`SPI_REG_DAC, 8'h60);
    write_reg(`SPI_REG_ADC, 8'h0C);
    check_pins();
    // set and clear together without overlap
    write_reg(`SPI_REG_LED, 8'h42);
    write_reg(`SPI_REG_MUX, 8'h5A);
    check_pins();
    read_all();
  endtask

  task automatic test_toggle();
    repeat (2)
    begin
      write_reg(`SPI_REG_LED, 8'h36);
      write_reg(`SPI_REG_DAC, 8'h99);
      check_pins();
      read_check("toggle led", `SPI_REG_LED);
      read_check("toggle dac", `SPI_REG_DAC);
    end
  endtask

  task automatic test_commands();
    write_reg(`SPI_REG_LED, 8'h0F);
    write_reg(`SPI_REG_4094, 8'h0A);
    write_reg(`SPI_REG_DAC, 8'h0F);
    write_reg(`SPI_REG_ADC, 8'h03);
    write_reg(`SPI_REG_MUX, 8'h03);
    // soft reset keeps the 4094 outputs
    write_reg(`SPI_REG_SOFT_RESET, 8'h00);
    check_pins();
    read_check("mux after soft reset", `SPI_REG_MUX);
    write_reg(`SPI_REG_LED, 8'h05);
    write_reg(`SPI_REG_DAC, 8'h06);
    write_reg(`SPI_REG_ADC, 8'h09);
    write_reg(`SPI_REG_MUX, 8'h02);
    // power-up clears led and adc only
    write_reg(`SPI_REG_POWERUP, 8'h00);
    check_pins();
    read_check("mux after power-up", `SPI_REG_MUX);
  endtask

  task automatic test_routing();
    logic [7:0] pattern;
    for (int m = 0; m <= 9; m++)
    begin
      write_reg(`SPI_REG_MUX, 8'(m));
      rand_byte(pattern);
      @(posedge clk);
      periph_miso <= pattern;
      cs2_n       <= 1'b0;
      // 3 cycles through the synchronizer
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_value("periph_cs", 16'(periph_cs), 16'(expected_cs(m)));
      check_value("miso", 16'(miso), 16'(expected_miso(m, pattern)));
      // miso follows a new pattern combinationally
      rand_byte(pattern);
      @(posedge clk);
      periph_miso <= pattern;
      @(negedge clk);
      check_value("miso", 16'(miso), 16'(expected_miso(m, pattern)));
      @(posedge clk);
      cs2_n <= 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_value("periph_cs", 16'(periph_cs), 16'(CS_IDLE));
      check_value("miso", 16'(miso), 16'h0000);
    end
    write_reg(`SPI_REG_MUX, 8'h00);
  endtask

  task automatic test_short_frame();
    logic [15:0] rx;
    // nonzero led so that a stray write would show
    write_reg(`SPI_REG_LED, 8'h0A);
    // cut after 12 bits with set bits already shifted in
    spi_frame(`SPI_REG_LED, 8'hF0, 12, rx);
    check_pins();
    read_check("led after short frame", `SPI_REG_LED);
  endtask

  //////////////////////////////////////////////////////////////////////
  initial
  begin
    reset       = 1'b1;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    cs2_n       = 1'b1;
    mosi        = 1'b0;
    periph_miso = '0;
    lfsr_state  = 16'd42;
    error_count = 0;
    check_count = 0;
    model       = '0;
    model.dac   = `SPI_DAC_RESET_VAL;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    test_reset_state();
    test_write_readback();
    test_toggle();
    test_commands();
    test_routing();
    test_short_frame();

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
